// File: build.f
logic/msg_pkg.sv
logic/store_pkg.sv
logic/slot_allocator.sv
logic/bank_ram.sv
logic/list_ctrl.sv
logic/head_buffer.sv
logic/release_arbiter.sv
logic/message_bank.sv
tests/tb_message_bank.sv

// File: logic/bank_ram.sv
/*
  Simple dual-port RAM with one word per store slot.
  Writes are synchronous, reads are registered and return data one cycle later.
*/
`timescale 1ns/1ps

module bank_ram #(
  parameter int Width = 8
) (
  input  logic             clk_i,
  input  logic             wr_en_i,
  input  store_pkg::slot_t wr_addr_i,
  input  logic [Width-1:0] wr_data_i,
  input  logic             rd_en_i,
  input  store_pkg::slot_t rd_addr_i,
  output logic [Width-1:0] rd_data_o
);

  logic [Width-1:0] mem_q [store_pkg::NumSlots];

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

  // Same address read and write gives the old word
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_o <= mem_q[rd_addr_i];
    end
  end

endmodule

// File: logic/head_buffer.sv
/*
  One message buffer per identifier, holding the head of its list.
  Filled one cycle after a fetch from the payload RAM, emptied by a release,
  which also hands the slot back to the allocator.
*/
`timescale 1ns/1ps

module head_buffer (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  store_pkg::fetch_t                     fetch_i,
  input  msg_pkg::payload_t                     msg_rd_data_i,
  input  msg_pkg::id_vec_t                      pop_i,
  output msg_pkg::id_vec_t                      fetch_req_o,
  output msg_pkg::id_vec_t                      buf_ready_o,
  output msg_pkg::payload_t [msg_pkg::NumIds-1:0] buf_msg_o,
  output store_pkg::release_t                   release_o
);

  store_pkg::head_state_e                 state_q [msg_pkg::NumIds];
  store_pkg::slot_t                       slot_q  [msg_pkg::NumIds];
  msg_pkg::payload_t [msg_pkg::NumIds-1:0] payload_q;
  store_pkg::fetch_t                      fetch_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < msg_pkg::NumIds; i++) begin
        state_q[i] <= store_pkg::HEAD_EMPTY;
      end
      fetch_q <= '0;
    end else begin
      fetch_q <= fetch_i;
      for (int i = 0; i < msg_pkg::NumIds; i++) begin
        unique case (state_q[i])
          store_pkg::HEAD_EMPTY: begin
            if (fetch_i.valid && (fetch_i.id == msg_pkg::id_t'(i))) begin
              state_q[i] <= store_pkg::HEAD_FETCH;
            end
          end
          // Read data is on the RAM output now
          store_pkg::HEAD_FETCH: begin
            if (fetch_q.valid && (fetch_q.id == msg_pkg::id_t'(i))) begin
              state_q[i] <= store_pkg::HEAD_READY;
            end
          end
          store_pkg::HEAD_READY: begin
            if (pop_i[i]) begin
              state_q[i] <= store_pkg::HEAD_EMPTY;
            end
          end
          default: state_q[i] <= store_pkg::HEAD_EMPTY;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_q.valid) begin
      payload_q[fetch_q.id] <= msg_rd_data_i;
      slot_q[fetch_q.id]    <= fetch_q.slot;
    end
  end

  always_comb begin
    for (int i = 0; i < msg_pkg::NumIds; i++) begin
      fetch_req_o[i] = (state_q[i] == store_pkg::HEAD_EMPTY);
      buf_ready_o[i] = (state_q[i] == store_pkg::HEAD_READY);
    end
  end

  assign buf_msg_o = payload_q;

  // Pop is one-hot, so at most one slot is freed
  always_comb begin
    release_o = '0;
    for (int i = 0; i < msg_pkg::NumIds; i++) begin
      if (pop_i[i]) begin
        release_o.valid = 1'b1;
        release_o.slot  = slot_q[i];
      end
    end
  end

endmodule

// File: logic/list_ctrl.sv
/*
  Accepts input messages and links them into one list per identifier.
  Also picks one head per cycle to fetch into the head buffers and
  follows the next pointer when the fetch returns.
*/
`timescale 1ns/1ps

module list_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  msg_pkg::msg_t       msg_i,
  input  logic                in_valid_i,
  input  logic                slot_avail_i,
  input  store_pkg::slot_t    free_slot_i,
  input  msg_pkg::id_vec_t    fetch_req_i,
  input  store_pkg::slot_t    next_rd_data_i,
  output logic                alloc_o,
  output store_pkg::msg_wr_t  msg_wr_o,
  output store_pkg::next_wr_t next_wr_o,
  output store_pkg::fetch_t   fetch_o
);

  // Head and count cover only the entries not yet fetched
  store_pkg::slot_t  head_q  [msg_pkg::NumIds];
  store_pkg::slot_t  head_d  [msg_pkg::NumIds];
  store_pkg::slot_t  tail_q  [msg_pkg::NumIds];
  store_pkg::slot_t  tail_d  [msg_pkg::NumIds];
  store_pkg::count_t count_q [msg_pkg::NumIds];
  store_pkg::count_t count_d [msg_pkg::NumIds];
  store_pkg::fetch_t fetch_q;
  msg_pkg::id_vec_t  fetch_ok;
  logic              accept;
  logic [1:0]        bank_wr_en;

  assign accept  = in_valid_i && slot_avail_i;
  assign alloc_o = accept;

  // Write enables per RAM bank
  always_comb begin
    bank_wr_en = '0;
    bank_wr_en[store_pkg::MSG_BANK]  = accept;
    bank_wr_en[store_pkg::NEXT_BANK] = accept && (count_q[msg_i.id] != '0);
  end

  always_comb begin
    msg_wr_o.en   = bank_wr_en[store_pkg::MSG_BANK];
    msg_wr_o.addr = free_slot_i;
    msg_wr_o.data = msg_i.payload;
    // Old tail points at the new slot
    next_wr_o.en   = bank_wr_en[store_pkg::NEXT_BANK];
    next_wr_o.addr = tail_q[msg_i.id];
    next_wr_o.data = free_slot_i;
  end

  // Never fetch a list that is being appended to in the same cycle
  always_comb begin
    for (int i = 0; i < msg_pkg::NumIds; i++) begin
      fetch_ok[i] = fetch_req_i[i] && (count_q[i] != '0) &&
                    !(accept && (msg_i.id == msg_pkg::id_t'(i)));
    end
    fetch_o = '0;
    for (int i = msg_pkg::NumIds - 1; i >= 0; i--) begin
      if (fetch_ok[i]) begin
        fetch_o.valid = 1'b1;
        fetch_o.id    = msg_pkg::id_t'(i);
        fetch_o.slot  = head_q[i];
      end
    end
  end

  always_comb begin
    head_d  = head_q;
    tail_d  = tail_q;
    count_d = count_q;
    // Returned next pointer is the new head if entries remain
    if (fetch_q.valid && (count_q[fetch_q.id] != '0)) begin
      head_d[fetch_q.id] = next_rd_data_i;
    end
    if (fetch_o.valid) begin
      count_d[fetch_o.id] = count_q[fetch_o.id] - store_pkg::count_t'(1);
    end
    if (accept) begin
      if (count_q[msg_i.id] == '0) begin
        head_d[msg_i.id] = free_slot_i;
      end
      tail_d[msg_i.id]  = free_slot_i;
      count_d[msg_i.id] = count_q[msg_i.id] + store_pkg::count_t'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < msg_pkg::NumIds; i++) begin
        head_q[i]  <= '0;
        tail_q[i]  <= '0;
        count_q[i] <= '0;
      end
      fetch_q <= '0;
    end else begin
      head_q  <= head_d;
      tail_q  <= tail_d;
      count_q <= count_d;
      fetch_q <= fetch_o;
    end
  end

endmodule

// File: logic/message_bank.sv
/*
  Linked-list message bank top level.
  Messages are stored per identifier and released in order, for enabled
  identifiers only, through a valid/ready output.
*/
`timescale 1ns/1ps

module message_bank (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  msg_pkg::msg_t    msg_i,
  input  logic             in_valid_i,
  output logic             in_ready_o,
  input  msg_pkg::id_vec_t release_en_i,
  output msg_pkg::msg_t    msg_o,
  output logic             out_valid_o,
  input  logic             out_ready_i
);

  logic                                    alloc;
  store_pkg::slot_t                        free_slot;
  store_pkg::release_t                     slot_release;
  store_pkg::msg_wr_t                      msg_wr;
  store_pkg::next_wr_t                     next_wr;
  store_pkg::fetch_t                       fetch;
  msg_pkg::payload_t                       msg_rd_data;
  store_pkg::slot_t                        next_rd_data;
  msg_pkg::id_vec_t                        fetch_req;
  msg_pkg::id_vec_t                        buf_ready;
  msg_pkg::payload_t [msg_pkg::NumIds-1:0] buf_msg;
  msg_pkg::id_vec_t                        pop;

  slot_allocator slot_allocator_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .alloc_i      (alloc),
    .release_i    (slot_release),
    .free_slot_o  (free_slot),
    .slot_avail_o (in_ready_o)
  );

  list_ctrl list_ctrl_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .msg_i          (msg_i),
    .in_valid_i     (in_valid_i),
    .slot_avail_i   (in_ready_o),
    .free_slot_i    (free_slot),
    .fetch_req_i    (fetch_req),
    .next_rd_data_i (next_rd_data),
    .alloc_o        (alloc),
    .msg_wr_o       (msg_wr),
    .next_wr_o      (next_wr),
    .fetch_o        (fetch)
  );

  // Both banks are read at the fetched head slot
  bank_ram #(
    .Width (msg_pkg::PayloadWidth)
  ) msg_ram_i (
    .clk_i     (clk_i),
    .wr_en_i   (msg_wr.en),
    .wr_addr_i (msg_wr.addr),
    .wr_data_i (msg_wr.data),
    .rd_en_i   (fetch.valid),
    .rd_addr_i (fetch.slot),
    .rd_data_o (msg_rd_data)
  );

  bank_ram #(
    .Width (store_pkg::SlotWidth)
  ) next_ram_i (
    .clk_i     (clk_i),
    .wr_en_i   (next_wr.en),
    .wr_addr_i (next_wr.addr),
    .wr_data_i (next_wr.data),
    .rd_en_i   (fetch.valid),
    .rd_addr_i (fetch.slot),
    .rd_data_o (next_rd_data)
  );

  head_buffer head_buffer_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_i       (fetch),
    .msg_rd_data_i (msg_rd_data),
    .pop_i         (pop),
    .fetch_req_o   (fetch_req),
    .buf_ready_o   (buf_ready),
    .buf_msg_o     (buf_msg),
    .release_o     (slot_release)
  );

  release_arbiter release_arbiter_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .buf_ready_i  (buf_ready),
    .buf_msg_i    (buf_msg),
    .release_en_i (release_en_i),
    .out_ready_i  (out_ready_i),
    .pop_o        (pop),
    .msg_o        (msg_o),
    .out_valid_o  (out_valid_o)
  );

endmodule

// File: logic/msg_pkg.sv
/*
  Message format shared by every stage of the message bank.
  A message is a payload tagged with a small identifier that selects its queue.
*/
package msg_pkg;

  localparam int IdWidth      = 2;
  localparam int NumIds       = 2 ** IdWidth;
  localparam int PayloadWidth = 16;

  typedef logic [IdWidth-1:0]      id_t;
  typedef logic [PayloadWidth-1:0] payload_t;

  // Identifier sits in the low bits
  typedef struct packed {
    payload_t payload;
    id_t      id;
  } msg_t;

  // One bit per identifier
  typedef logic [NumIds-1:0] id_vec_t;

endpackage

// File: logic/release_arbiter.sv
/*
  Picks the lowest ready and enabled identifier and presents its message.
  Under stall the pick is held so the output stays stable.
*/
`timescale 1ns/1ps

module release_arbiter (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  msg_pkg::id_vec_t                      buf_ready_i,
  input  msg_pkg::payload_t [msg_pkg::NumIds-1:0] buf_msg_i,
  input  msg_pkg::id_vec_t                      release_en_i,
  input  logic                                  out_ready_i,
  output msg_pkg::id_vec_t                      pop_o,
  output msg_pkg::msg_t                         msg_o,
  output logic                                  out_valid_o
);

  msg_pkg::id_vec_t eligible;
  msg_pkg::id_t     grant_id;
  logic             lock_q;
  msg_pkg::id_t     lock_id_q;

  assign eligible = buf_ready_i & release_en_i;

  // Locked pick survives only while its enable stays high
  always_comb begin
    grant_id = '0;
    for (int i = msg_pkg::NumIds - 1; i >= 0; i--) begin
      if (eligible[i]) begin
        grant_id = msg_pkg::id_t'(i);
      end
    end
    if (lock_q && eligible[lock_id_q]) begin
      grant_id = lock_id_q;
    end
  end

  assign out_valid_o = |eligible;

  always_comb begin
    pop_o = '0;
    pop_o[grant_id] = out_valid_o && out_ready_i;
  end

  assign msg_o.payload = buf_msg_i[grant_id];
  assign msg_o.id      = grant_id;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lock_q    <= 1'b0;
      lock_id_q <= '0;
    end else begin
      lock_q    <= out_valid_o && !out_ready_i;
      lock_id_q <= grant_id;
    end
  end

endmodule

// File: logic/slot_allocator.sv
/*
  Tracks which store slots hold a message and offers the lowest free one.
  A take or a release shows up in the outputs one cycle after the edge.
*/
`timescale 1ns/1ps

module slot_allocator (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                alloc_i,
  input  store_pkg::release_t release_i,
  output store_pkg::slot_t    free_slot_o,
  output logic                slot_avail_o
);

  logic [store_pkg::NumSlots-1:0] used_q;
  logic [store_pkg::NumSlots-1:0] used_d;

  // Lowest clear bit wins, so scan downwards
  always_comb begin
    free_slot_o = '0;
    for (int s = store_pkg::NumSlots - 1; s >= 0; s--) begin
      if (!used_q[s]) begin
        free_slot_o = store_pkg::slot_t'(s);
      end
    end
  end

  assign slot_avail_o = ~&used_q;

  // Taken and freed slots never coincide
  always_comb begin
    used_d = used_q;
    if (alloc_i) begin
      used_d[free_slot_o] = 1'b1;
    end
    if (release_i.valid) begin
      used_d[release_i.slot] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      used_q <= '0;
    end else begin
      used_q <= used_d;
    end
  end

endmodule

// File: logic/store_pkg.sv
/*
  Slot store description for the message bank: capacity, slot addresses,
  the write and fetch records exchanged between stages and the head buffer states.
*/
package store_pkg;

  localparam int NumSlots  = 16;
  localparam int SlotWidth = $clog2(NumSlots);

  typedef logic [SlotWidth-1:0] slot_t;
  // Must be able to hold NumSlots itself
  typedef logic [SlotWidth:0]   count_t;

  typedef enum logic {
    MSG_BANK,
    NEXT_BANK
  } ram_bank_e;

  typedef struct packed {
    logic              en;
    slot_t             addr;
    msg_pkg::payload_t data;
  } msg_wr_t;

  typedef struct packed {
    logic  en;
    slot_t addr;
    slot_t data;
  } next_wr_t;

  // Head read in flight
  typedef struct packed {
    logic         valid;
    msg_pkg::id_t id;
    slot_t        slot;
  } fetch_t;

  typedef struct packed {
    logic  valid;
    slot_t slot;
  } release_t;

  typedef enum logic [1:0] {
    HEAD_EMPTY,
    HEAD_FETCH,
    HEAD_READY
  } head_state_e;

endpackage

// File: run.sh
#!/usr/bin/env bash
# Builds the message bank testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -f build.f --top-module tb_message_bank -Mdir obj_dir -o sim_message_bank \
  && ./obj_dir/sim_message_bank 2>&1 | tee sim.log \
  || { echo "Build or simulation run did not complete"; exit 1; }
grep -qx "test failed" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -qx "test passed" sim.log || { echo "No result found in sim.log"; exit 1; }
exit 0

// File: tests/tb_message_bank.sv
/*
  Random-stimulus testbench for the message bank.
  A per-identifier queue model and an occupancy count check ordering,
  release enables, the store-full level and output stability under stall.
*/
`timescale 1ns/1ps

module tb_message_bank;

  localparam int ClkPeriod   = 4;
  localparam int ResetCycles = 10;
  localparam int RandCycles  = 3000;
  localparam int FillCycles  = store_pkg::NumSlots + 8;
  localparam int MaskCycles  = 1000;
  localparam int DrainCycles = 200;
  localparam int TotalCycles = ResetCycles + RandCycles + FillCycles + MaskCycles +
                               DrainCycles + 20;
  localparam logic [15:0]  Seed     = 16'd38925;
  localparam msg_pkg::id_t MaskedId = msg_pkg::id_t'(2);

  logic             clk_i = 1'b0;
  logic             rst_ni;
  msg_pkg::msg_t    msg_i;
  logic             in_valid_i;
  logic             in_ready_o;
  msg_pkg::id_vec_t release_en_i;
  msg_pkg::msg_t    msg_o;
  logic             out_valid_o;
  logic             out_ready_i;

  // Reference model
  msg_pkg::payload_t model_q [msg_pkg::NumIds][$];
  int                occupancy = 0;

  logic [15:0]       lfsr_q = Seed;
  logic              checking = 1'b0;
  logic              masked_active = 1'b0;
  logic              saw_full = 1'b0;
  logic              stall_pending = 1'b0;
  msg_pkg::msg_t     stall_msg = '0;
  msg_pkg::id_t      rel_id;
  msg_pkg::payload_t expected;
  logic              exp_ready;
  int                checks = 0;
  int                value_errors = 0;
  int                other_errors = 0;

  message_bank dut_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .msg_i        (msg_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .release_en_i (release_en_i),
    .msg_o        (msg_o),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic int model_total();
    int n;
    n = 0;
    for (int i = 0; i < msg_pkg::NumIds; i++) begin
      n += model_q[i].size();
    end
    return n;
  endfunction

  task automatic value_error(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    value_errors++;
    $display("FAILED %s: expected %0h, actual %0h at %0t", name, exp_val, act_val, $time);
  endtask

  task automatic protocol_error(input string what);
    other_errors++;
    $display("ERROR: %s at %0t", what, $time);
  endtask

  // Outputs are stable at the falling edge and the model follows committed transfers
  always @(negedge clk_i) begin
    if (checking) begin
      checks++;
      exp_ready = (occupancy < store_pkg::NumSlots);
      if (in_ready_o !== exp_ready) begin
        value_error("in_ready_o vs occupancy", 32'(exp_ready), 32'(in_ready_o));
      end
      if (!in_ready_o) begin
        saw_full = 1'b1;
      end
      // Held output while the stalled identifier stays enabled
      if (stall_pending && release_en_i[stall_msg.id]) begin
        checks++;
        if (out_valid_o !== 1'b1) begin
          protocol_error("out_valid_o dropped while stalled");
        end else if (msg_o !== stall_msg) begin
          value_error("msg_o held under stall", 32'(stall_msg), 32'(msg_o));
        end
      end
      stall_pending = out_valid_o && !out_ready_i;
      stall_msg     = msg_o;
      if (out_valid_o && out_ready_i) begin
        rel_id = msg_o.id;
        checks++;
        if (!release_en_i[rel_id]) begin
          protocol_error($sformatf("id %0d released with its enable low", rel_id));
        end
        if (masked_active && (rel_id == MaskedId)) begin
          protocol_error($sformatf("masked id %0d was released", rel_id));
        end
        if (model_q[rel_id].size() == 0) begin
          protocol_error($sformatf("id %0d released with no message queued", rel_id));
        end else begin
          expected = model_q[rel_id].pop_front();
          if (msg_o.payload !== expected) begin
            value_error($sformatf("payload of id %0d", rel_id), 32'(expected),
                        32'(msg_o.payload));
          end
        end
        occupancy--;
      end
      if (in_valid_i && in_ready_o) begin
        model_q[msg_i.id].push_back(msg_i.payload);
        occupancy++;
      end
    end
  end

  task automatic random_traffic(input int cycles, input msg_pkg::id_vec_t en_mask);
    msg_pkg::msg_t    m;
    msg_pkg::id_vec_t en_a;
    msg_pkg::id_vec_t en_b;
    for (int c = 0; c < cycles; c++) begin
      @(posedge clk_i);
      m.id         = msg_pkg::id_t'(take_bits(msg_pkg::IdWidth));
      m.payload    = msg_pkg::payload_t'(take_bits(msg_pkg::PayloadWidth));
      en_a         = msg_pkg::id_vec_t'(take_bits(msg_pkg::NumIds));
      en_b         = msg_pkg::id_vec_t'(take_bits(msg_pkg::NumIds));
      msg_i        <= m;
      in_valid_i   <= (take_bits(1) != 0);
      release_en_i <= (en_a | en_b) & en_mask;
      out_ready_i  <= (take_bits(2) != 0);
    end
  endtask

  // Output disabled, so the store must run full
  task automatic fill_store();
    msg_pkg::msg_t m;
    saw_full = 1'b0;
    for (int c = 0; c < FillCycles; c++) begin
      @(posedge clk_i);
      m.id         = msg_pkg::id_t'(take_bits(msg_pkg::IdWidth));
      m.payload    = msg_pkg::payload_t'(take_bits(msg_pkg::PayloadWidth));
      msg_i        <= m;
      in_valid_i   <= 1'b1;
      release_en_i <= '0;
      out_ready_i  <= take_bits(1) != 0;
    end
    @(negedge clk_i);
    if (!saw_full) begin
      protocol_error("in_ready_o never dropped with output disabled");
    end
  endtask

  task automatic drain_all();
    int waited;
    @(posedge clk_i);
    in_valid_i    <= 1'b0;
    release_en_i  <= '1;
    out_ready_i   <= 1'b1;
    masked_active = 1'b0;
    waited = 0;
    while ((model_total() != 0) && (waited < DrainCycles)) begin
      @(posedge clk_i);
      waited++;
    end
    if (model_total() != 0) begin
      protocol_error($sformatf("%0d messages still queued after drain", model_total()));
    end
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    checks++;
    if (out_valid_o !== 1'b0) begin
      value_error("out_valid_o after drain", 32'(0), 32'(out_valid_o));
    end
    if (in_ready_o !== 1'b1) begin
      value_error("in_ready_o after drain", 32'(1), 32'(in_ready_o));
    end
  endtask

  initial begin
    rst_ni       = 1'b0;
    msg_i        = '0;
    in_valid_i   = 1'b0;
    release_en_i = '0;
    out_ready_i  = 1'b0;
    repeat (ResetCycles) @(posedge clk_i);
    rst_ni   <= 1'b1;
    checking = 1'b1;
    @(negedge clk_i);
    checks++;
    if (out_valid_o !== 1'b0) begin
      value_error("out_valid_o after reset", 32'(0), 32'(out_valid_o));
    end
    if (in_ready_o !== 1'b1) begin
      value_error("in_ready_o after reset", 32'(1), 32'(in_ready_o));
    end
    random_traffic(RandCycles, '1);
    fill_store();
    masked_active = 1'b1;
    random_traffic(MaskCycles, ~(msg_pkg::id_vec_t'(1) << MaskedId));
    drain_all();
    $display("Summary: %0d checks, %0d value errors, %0d other errors",
             checks, value_errors, other_errors);
    if ((value_errors + other_errors) == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog sized from the phase lengths with a factor of two margin
  initial begin
    #(TotalCycles * ClkPeriod * 2);
    $display("ERROR: watchdog expired, the run did not complete in time");
    $display("test failed");
    $finish;
  end

endmodule
